// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run cp0_tb, search $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module cp0_tb -f list.f
	./obj_dir/Vcp0_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: list.f
logic/cp0_pkg.sv
logic/cp0_timer.sv
logic/cp0_regs.sv
logic/cp0_top.sv
sim/cp0_tb.sv

// File: logic/cp0_pkg.sv
package cp0_pkg;

    // implemented register indices, select 0 only
    typedef enum logic [4:0] {
        reg_badvaddr = 5'd8,
        reg_count    = 5'd9,
        reg_compare  = 5'd11,
        reg_status   = 5'd12,
        reg_cause    = 5'd13,
        reg_epc      = 5'd14
    } cp0_reg_t;

    typedef enum logic [4:0] {
        exc_int  = 5'h00,               // interrupt
        exc_adel = 5'h04,               // address error on load or fetch
        exc_ades = 5'h05,               // address error on store
        exc_sys  = 5'h08,               // syscall
        exc_bp   = 5'h09,               // breakpoint
        exc_ri   = 5'h0a,               // reserved instruction
        exc_ov   = 5'h0c                // arithmetic overflow
    } exc_code_t;

    typedef struct packed {
        logic [3:0] cu;                 // coprocessor usable, only cu0 kept
        logic [4:0] rsvd1;
        logic       bev;                // boot exception vectors
        logic [5:0] rsvd2;
        logic [7:0] im;                 // interrupt mask
        logic [4:0] rsvd3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic       bd;                 // last exception in a delay slot
        logic       ti;
        logic [5:0] rsvd1;
        logic       iv;
        logic [6:0] rsvd2;
        logic [7:0] ip;                 // pending, [1:0] are software bits
        logic       rsvd3;
        exc_code_t  exc_code;
        logic [1:0] rsvd4;
    } cause_t;

    typedef struct packed {
        logic        write;
        cp0_reg_t    idx;               // also selects the read
        logic [31:0] data;
    } cp0_access_t;

    typedef struct packed {
        logic        valid;
        exc_code_t   code;
        logic [31:0] pc;
        logic        in_delay_slot;
        logic        bad_addr_valid;
        logic [31:0] bad_addr;
    } exc_req_t;

    localparam status_t status_reset = '{
        cu      : 4'b0001,
        bev     : 1'b1,
        erl     : 1'b1,
        default : '0
    };

    // bits a Status write may change
    localparam status_t status_wmask = '{
        cu      : 4'b0001,
        bev     : 1'b1,
        im      : 8'hff,
        erl     : 1'b1,
        exl     : 1'b1,
        ie      : 1'b1,
        default : '0
    };

endpackage

// File: logic/cp0_regs.sv
`timescale 1ns/1ns

module cp0_regs import cp0_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  cp0_access_t acc,
    input  exc_req_t    exc,
    input  logic        eret,
    input  logic [5:0]  ext_int,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    input  logic        timer_int,
    output logic        timer_wr,
    output cp0_reg_t    timer_sel,
    output logic [31:0] rdata,
    output logic [31:0] epc,
    output logic        interrupt
);

    logic [31:0] badvaddr_q;
    logic [31:0] badvaddr_nxt;
    logic [31:0] epc_q;
    logic [31:0] epc_nxt;
    status_t     status_q;
    status_t     status_nxt;
    cause_t      cause_q;
    cause_t      cause_nxt;

    logic        exc_take;                      // exception not overridden by eret
    logic        wr_ok;                         // access write survives priority
    logic [7:0]  hw_ip;
    logic [7:0]  pending;
    logic        int_en;

    assign exc_take = exc.valid && !eret;
    assign wr_ok    = acc.write && !exc.valid && !eret;

    // ip[7] shares the timer with the top external line
    assign hw_ip = {ext_int[5] | timer_int, ext_int[4:0], 2'b00};

    // level is taken from live inputs, not the registered ip copy
    assign pending   = (hw_ip | {6'b0, cause_q.ip[1:0]}) & status_q.im;
    assign int_en    = status_q.ie && !status_q.exl;
    assign interrupt = (|pending) && int_en;

    // Count and Compare live in the timer
    assign timer_wr  = wr_ok && (acc.idx == reg_count || acc.idx == reg_compare);
    assign timer_sel = acc.idx;

    assign epc = epc_q;

    always_comb begin
        badvaddr_nxt = badvaddr_q;
        epc_nxt      = epc_q;
        status_nxt   = status_q;
        cause_nxt    = cause_q;

        cause_nxt.ip[7:2] = hw_ip[7:2];         // sampled every cycle

        if (eret) begin
            status_nxt.exl = 1'b0;
        end else if (exc.valid) begin
            cause_nxt.exc_code = exc.code;
            if (exc.bad_addr_valid) begin
                badvaddr_nxt = exc.bad_addr;
            end
            // nested exception keeps the first return point
            if (!status_q.exl) begin
                status_nxt.exl = 1'b1;
                cause_nxt.bd   = exc.in_delay_slot;
                if (exc.in_delay_slot) begin
                    epc_nxt = exc.pc - 32'd4;   // back to the branch
                end else begin
                    epc_nxt = exc.pc;
                end
            end
        end else if (acc.write) begin
            case (acc.idx)
                reg_status: begin
                    status_nxt = status_t'((acc.data & status_wmask) |
                                           (status_q & ~status_wmask));
                end
                reg_cause: begin
                    cause_nxt.ip[1:0] = acc.data[9:8];  // software interrupts
                    cause_nxt.iv      = acc.data[23];
                end
                reg_epc: begin
                    epc_nxt = acc.data;
                end
                default: begin
                    // Count and Compare go out on timer_wr, others ignored
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            badvaddr_q <= '0;
            epc_q      <= '0;
            status_q   <= status_reset;
            cause_q    <= '0;
        end else begin
            badvaddr_q <= badvaddr_nxt;
            epc_q      <= epc_nxt;
            status_q   <= status_nxt;
            cause_q    <= cause_nxt;
        end
    end

    // read port
    always_comb begin
        case (acc.idx)
            reg_badvaddr: rdata = badvaddr_q;
            reg_count:    rdata = count;
            reg_compare:  rdata = compare;
            reg_status:   rdata = status_q;
            reg_cause:    rdata = cause_q;
            reg_epc:      rdata = epc_q;
            default:      rdata = '0;       // unimplemented index
        endcase
    end

    // pipeline never retires an exception and an eret together
    a_exc_eret_excl: assert property (
        @(posedge clk) disable iff (!resetn)
        !(exc.valid && eret)
    ) else $error("exception and eret in the same cycle");

    // any taken exception leaves the core at exception level
    a_exc_sets_exl: assert property (
        @(posedge clk) disable iff (!resetn)
        exc_take |=> status_q.exl
    ) else $error("EXL not set after exception");

endmodule

// File: logic/cp0_timer.sv
`timescale 1ns/1ns

module cp0_timer import cp0_pkg::*; #(
    parameter int count_div_log2 = 1
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        timer_wr,
    input  cp0_reg_t    timer_sel,
    input  logic [31:0] wdata,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timer_int
);

    // a zero-width divider is not legal, keep one bit that never moves
    localparam int div_w = (count_div_log2 > 0) ? count_div_log2 : 1;
    localparam logic [div_w-1:0] div_last = div_w'((1 << count_div_log2) - 1);

    logic [div_w-1:0] div_cnt;
    logic             count_tick;
    logic             armed;                    // set by the first Compare write
    logic             match;
    logic             wr_count;
    logic             wr_compare;

    assign wr_count   = timer_wr && (timer_sel == reg_count);
    assign wr_compare = timer_wr && (timer_sel == reg_compare);
    assign count_tick = (div_cnt == div_last);
    assign match      = armed && (count == compare);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_cnt <= '0;
            count   <= '0;
        end else if (wr_count) begin
            count   <= wdata;
            div_cnt <= '0;                      // restart the divider
        end else begin
            div_cnt <= count_tick ? '0 : div_cnt + 1'b1;
            if (count_tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            compare   <= '0;
            armed     <= 1'b0;
            timer_int <= 1'b0;
        end else if (wr_compare) begin
            compare   <= wdata;
            armed     <= 1'b1;
            timer_int <= 1'b0;                  // acknowledge
        end else if (match) begin
            timer_int <= 1'b1;                  // sticky until next Compare write
        end
    end

    // regs block must only forward Count or Compare writes
    a_timer_sel: assert property (
        @(posedge clk) disable iff (!resetn)
        timer_wr |-> (timer_sel inside {reg_count, reg_compare})
    ) else $error("timer write with bad select %0d", timer_sel);

endmodule

// File: logic/cp0_top.sv
`timescale 1ns/1ns

module cp0_top import cp0_pkg::*; #(
    parameter int count_div_log2 = 1                // Count rate is clk / 2**n, n in 0..3
) (
    input  logic        clk,
    input  logic        resetn,
    input  cp0_access_t acc,
    input  exc_req_t    exc,
    input  logic        eret,
    input  logic [5:0]  ext_int,
    output logic [31:0] rdata,
    output logic [31:0] epc,
    output logic        interrupt
);

    logic        timer_wr;
    cp0_reg_t    timer_sel;
    logic [31:0] count;
    logic [31:0] compare;
    logic        timer_int;

    cp0_regs regs_i (
        .clk       (clk),
        .resetn    (resetn),
        .acc       (acc),
        .exc       (exc),
        .eret      (eret),
        .ext_int   (ext_int),
        .count     (count),
        .compare   (compare),
        .timer_int (timer_int),
        .timer_wr  (timer_wr),
        .timer_sel (timer_sel),
        .rdata     (rdata),
        .epc       (epc),
        .interrupt (interrupt)
    );

    cp0_timer #(
        .count_div_log2 (count_div_log2)
    ) timer_i (
        .clk       (clk),
        .resetn    (resetn),
        .timer_wr  (timer_wr),
        .timer_sel (timer_sel),
        .wdata     (acc.data),                      // write data straight from the access
        .count     (count),
        .compare   (compare),
        .timer_int (timer_int)
    );

endmodule

// File: sim/cp0_tb.sv
`timescale 1ns/1ns

module cp0_tb import cp0_pkg::*;;

    localparam int count_div_log2 = 1;
    localparam int div_period     = 1 << count_div_log2;

    logic        clk = 1'b0;
    logic        resetn = 1'b0;
    cp0_access_t acc;
    exc_req_t    exc;
    logic        eret;
    logic [5:0]  ext_int;
    logic [31:0] rdata;
    logic [31:0] epc;
    logic        interrupt;

    integer      seed = 13261;
    int          n_checks = 0;
    int          n_errors = 0;
    int          chk0 = 0;                      // counts at start of current test
    int          err0 = 0;
    logic        seen_irq = 1'b0;               // DUT interrupt at last check

    // model of the CP0 state
    logic [31:0] m_badvaddr;
    logic [31:0] m_epc;
    logic [31:0] m_count;
    logic [31:0] m_compare;
    status_t     m_status;
    cause_t      m_cause;
    int          m_div;
    logic        m_armed;
    logic        m_tint;

    cp0_reg_t  impl_regs [6] = '{reg_badvaddr, reg_count, reg_compare,
                                 reg_status, reg_cause, reg_epc};
    exc_code_t codes [7]     = '{exc_int, exc_adel, exc_ades, exc_sys,
                                 exc_bp, exc_ri, exc_ov};

    cp0_top #(
        .count_div_log2 (count_div_log2)
    ) dut_i (
        .clk       (clk),
        .resetn    (resetn),
        .acc       (acc),
        .exc       (exc),
        .eret      (eret),
        .ext_int   (ext_int),
        .rdata     (rdata),
        .epc       (epc),
        .interrupt (interrupt)
    );

    always #20 clk = ~clk;

    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

    function automatic cp0_access_t acc_of(input logic w, input cp0_reg_t i,
                                           input logic [31:0] d);
        cp0_access_t a;
        a.write = w;
        a.idx   = i;
        a.data  = d;
        return a;
    endfunction

    function automatic exc_req_t exc_of(input exc_code_t c, input logic [31:0] pc,
                                        input logic ds, input logic bav,
                                        input logic [31:0] ba);
        exc_req_t e;
        e.valid          = 1'b1;
        e.code           = c;
        e.pc             = pc;
        e.in_delay_slot  = ds;
        e.bad_addr_valid = bav;
        e.bad_addr       = ba;
        return e;
    endfunction

    function automatic cp0_reg_t pick_idx();
        int k;
        k = $unsigned($random(seed)) % 8;
        if (k < 6) begin
            return impl_regs[k];
        end else begin
            return cp0_reg_t'(5'($random(seed)));   // mostly unimplemented
        end
    endfunction

    function automatic logic [31:0] model_rdata(input cp0_reg_t i);
        case (i)
            reg_badvaddr: return m_badvaddr;
            reg_count:    return m_count;
            reg_compare:  return m_compare;
            reg_status:   return m_status;
            reg_cause:    return m_cause;
            reg_epc:      return m_epc;
            default:      return 32'd0;
        endcase
    endfunction

    function automatic logic model_irq();
        logic [7:0] pend;
        pend = ({ext_int[5] | m_tint, ext_int[4:0], 2'b00} | {6'd0, m_cause.ip[1:0]})
               & m_status.im;
        return (|pend) && m_status.ie && !m_status.exl;
    endfunction

    // one clock edge of the model, inputs as driven this cycle
    task automatic model_step();
        logic [7:0] hw;
        logic       wr_ok;
        logic       match;
        cause_t     wc;
        status_t    ws;
        hw    = {ext_int[5] | m_tint, ext_int[4:0], 2'b00};
        wr_ok = acc.write && !exc.valid && !eret;
        match = m_armed && (m_count == m_compare);
        wc    = cause_t'(acc.data);
        ws    = status_t'(acc.data);
        if (wr_ok && acc.idx == reg_count) begin
            m_count = acc.data;
            m_div   = 0;
        end else if (m_div == div_period - 1) begin
            m_div   = 0;
            m_count = m_count + 32'd1;
        end else begin
            m_div   = m_div + 1;
        end
        if (wr_ok && acc.idx == reg_compare) begin
            m_compare = acc.data;
            m_armed   = 1'b1;
            m_tint    = 1'b0;
        end else if (match) begin
            m_tint    = 1'b1;
        end
        m_cause.ip[7:2] = hw[7:2];
        if (eret) begin
            m_status.exl = 1'b0;
        end else if (exc.valid) begin
            m_cause.exc_code = exc.code;
            if (exc.bad_addr_valid) begin
                m_badvaddr = exc.bad_addr;
            end
            if (!m_status.exl) begin                // first level only
                m_status.exl = 1'b1;
                m_cause.bd   = exc.in_delay_slot;
                m_epc        = exc.in_delay_slot ? exc.pc - 32'd4 : exc.pc;
            end
        end else if (acc.write) begin
            case (acc.idx)
                reg_status: begin                   // cu0, bev, im, erl, exl, ie
                    m_status.cu[0] = ws.cu[0];
                    m_status.bev   = ws.bev;
                    m_status.im    = ws.im;
                    m_status.erl   = ws.erl;
                    m_status.exl   = ws.exl;
                    m_status.ie    = ws.ie;
                end
                reg_cause: begin
                    m_cause.ip[1:0] = wc.ip[1:0];
                    m_cause.iv      = wc.iv;
                end
                reg_epc:    m_epc = acc.data;
                default: begin
                end
            endcase
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t: %s is %h, model has %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t: status is %h, model has %h (exl %b/%b ie %b/%b)",
                     $time, got, exp, got.exl, exp.exl, got.ie, exp.ie);
        end
    endtask

    task automatic check_cause(input cause_t got, input cause_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t: cause is %h, model has %h (ip %h/%h bd %b/%b)",
                     $time, got, exp, got.ip, exp.ip, got.bd, exp.bd);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t: interrupt is %b, model has %b", $time, got, exp);
        end
    endtask

    task automatic check_outputs();
        case (acc.idx)
            reg_status: check_status(status_t'(rdata), m_status);
            reg_cause:  check_cause(cause_t'(rdata), m_cause);
            default:    check_word("rdata", rdata, model_rdata(acc.idx));
        endcase
        check_word("epc", epc, m_epc);
        check_irq(interrupt, model_irq());
        seen_irq = interrupt;
    endtask

    // check last edge, drive on the falling edge, step model on the rising one
    task automatic run_cycle(input cp0_access_t a, input exc_req_t e, input logic r,
                             input logic [5:0] x);
        @(negedge clk);
        check_outputs();
        acc     = a;
        exc     = e;
        eret    = r;
        ext_int = x;
        @(posedge clk);
        model_step();
    endtask

    task automatic random_cycle(input int n_ops);
        int          op;
        cp0_access_t a;
        exc_req_t    e;
        logic        r;
        logic [5:0]  x;
        op = $unsigned($random(seed)) % n_ops;
        a  = acc_of(1'b0, pick_idx(), 32'd0);
        e  = '0;
        r  = 1'b0;
        x  = ext_int;
        case (op)
            0: a.idx = cp0_reg_t'(5'd0);                    // idle
            2: begin
                a.write = 1'b1;
                a.data  = $random(seed);
            end
            3: begin
                e = exc_of(codes[$unsigned($random(seed)) % 7],
                           32'($random(seed)) & ~32'd3, 1'($random(seed)),
                           1'($random(seed)), $random(seed));
                a.write = 1'($random(seed));                // must be dropped
                a.data  = $random(seed);
            end
            4: begin
                r       = 1'b1;
                a.write = 1'($random(seed));
                a.data  = $random(seed);
            end
            5: x = 6'($random(seed));
            default: begin                                  // plain read
            end
        endcase
        run_cycle(a, e, r, x);
    endtask

    task automatic report_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name,
                 n_checks - chk0, n_errors - err0);
        chk0 = n_checks;
        err0 = n_errors;
    endtask

    task automatic test_exception();
        exc_req_t none;
        none = '0;
        run_cycle(acc_of(1'b1, reg_status, 32'h1000_0000), none, 1'b0, ext_int);
        run_cycle(acc_of(1'b1, reg_epc, 32'h1234_5678),
                  exc_of(exc_adel, 32'h0040_0100, 1'b0, 1'b1, 32'h0000_0bad), 1'b0, ext_int);
        run_cycle(acc_of(1'b0, reg_epc, 32'd0), none, 1'b0, ext_int);
        // nested, EPC and bd stay
        run_cycle(acc_of(1'b1, reg_compare, 32'h0000_0055),
                  exc_of(exc_ov, 32'h0040_0200, 1'b1, 1'b0, 32'd0), 1'b0, ext_int);
        run_cycle(acc_of(1'b0, reg_cause, 32'd0), none, 1'b0, ext_int);
        run_cycle(acc_of(1'b1, reg_status, 32'h1000_ff03), none, 1'b1, ext_int);
        run_cycle(acc_of(1'b0, reg_status, 32'd0), none, 1'b0, ext_int);
        run_cycle(acc_of(1'b0, reg_badvaddr, 32'd0), none, 1'b0, ext_int);
        run_cycle(acc_of(1'b0, reg_compare, 32'd0),
                  exc_of(exc_sys, 32'h0040_0300, 1'b1, 1'b0, 32'd0), 1'b0, ext_int);
        run_cycle(acc_of(1'b0, reg_cause, 32'd0), none, 1'b0, ext_int);
        run_cycle(acc_of(1'b0, reg_epc, 32'd0), none, 1'b1, ext_int);
        run_cycle(acc_of(1'b0, reg_status, 32'd0), none, 1'b0, ext_int);
    endtask

    task automatic test_timer();
        exc_req_t none;
        status_t  st;
        int       n;
        none  = '0;
        st    = status_reset;
        st.erl = 1'b0;
        st.im  = 8'h80;                                     // timer line only
        st.ie  = 1'b1;
        run_cycle(acc_of(1'b1, reg_cause, 32'd0), none, 1'b0, 6'd0);
        run_cycle(acc_of(1'b1, reg_status, 32'(st)), none, 1'b0, 6'd0);
        run_cycle(acc_of(1'b1, reg_count, 32'h0000_0100), none, 1'b0, 6'd0);
        run_cycle(acc_of(1'b1, reg_compare, 32'h0000_0106), none, 1'b0, 6'd0);
        n = 0;
        while (!seen_irq && n < 64) begin
            run_cycle(acc_of(1'b0, reg_count, 32'd0), none, 1'b0, 6'd0);
            n++;
        end
        if (!seen_irq) begin
            $display("timer interrupt did not rise within 64 cycles");
            n_errors++;
        end
        repeat (3) run_cycle(acc_of(1'b0, reg_cause, 32'd0), none, 1'b0, 6'd0);
        run_cycle(acc_of(1'b1, reg_compare, 32'h0001_0000), none, 1'b0, 6'd0);
        repeat (4) run_cycle(acc_of(1'b0, reg_cause, 32'd0), none, 1'b0, 6'd0);
    endtask

    initial begin
        int n;
        acc        = acc_of(1'b0, cp0_reg_t'(5'd0), 32'd0);
        exc        = '0;
        eret       = 1'b0;
        ext_int    = 6'd0;
        m_badvaddr = '0;
        m_epc      = '0;
        m_count    = '0;
        m_compare  = '0;
        m_status   = status_reset;
        m_cause    = '0;
        m_div      = 0;
        m_armed    = 1'b0;
        m_tint     = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (resetn !== 1'b1 && n < 20);
        if (resetn !== 1'b1) begin
            $display("reset was never released");
            n_errors++;
        end
        model_step();                                       // first edge out of reset

        repeat (300) random_cycle(3);
        report_test("readback");
        test_exception();
        report_test("exception");
        repeat (2000) random_cycle(6);
        report_test("random");
        test_timer();
        @(negedge clk);
        check_outputs();
        report_test("timer");

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
